// File: design/credit_fifo.sv
`default_nettype none

module credit_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  push,
    input  wire  pop,
    input  wire  T din,
    output T     dout,
    output logic not_empty,
    output logic not_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign dout      = mem[rd_ptr];  // head is visible without a read cycle
    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the producer and consumer sit in other modules and must honour the flags
    no_overflow: assert property (@(posedge CLK) disable iff (RESET) push |-> not_full)
        else $error("credit_fifo: push while full");
    no_underflow: assert property (@(posedge CLK) disable iff (RESET) pop |-> not_empty)
        else $error("credit_fifo: pop while empty");

endmodule

`default_nettype wire

// File: design/eeprom_ctrl_top.sv
`default_nettype none
`include "eeprom_params.svh"

module eeprom_ctrl_top (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     cmd_valid,
    input  wire eeprom_pkg::eeprom_cmd_t cmd,
    input  wire                     rsp_credit,
    input  wire                     scl_in,
    input  wire                     sda_in,
    output logic                    cmd_credit,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl_oe,
    output logic                    sda_oe
);
    import eeprom_pkg::*;

    eeprom_cmd_t cmd_head;
    logic        cmd_ready;
    logic        rsp_push;
    eeprom_rsp_t seq_rsp;
    logic        rsp_room;

    // each pop frees a slot, so it doubles as the host credit
    credit_fifo #(
        .T     (eeprom_cmd_t),
        .DEPTH (`CMD_DEPTH)
    ) cmd_q (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (cmd_valid),
        .pop       (cmd_credit),
        .din       (cmd),
        .dout      (cmd_head),
        .not_empty (cmd_ready),
        .not_full  ()
    );

    i2c_eeprom_master seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_ready (cmd_ready),
        .cmd       (cmd_head),
        .rsp_room  (rsp_room),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .cmd_pop   (cmd_credit),
        .rsp_push  (rsp_push),
        .rsp       (seq_rsp),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe)
    );

    eeprom_rsp_out rsp_out (
        .CLK        (CLK),
        .RESET      (RESET),
        .rsp_push   (rsp_push),
        .rsp_in     (seq_rsp),
        .rsp_credit (rsp_credit),
        .rsp_room   (rsp_room),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// File: design/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// command queue depth, also the host's credits after reset
`define CMD_DEPTH 4

// response buffer slots
`define RSP_DEPTH 2

// CLK cycles per half SCL period
`define SCL_HALF 4

`endif

// File: design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // device type nibble of the control byte
    localparam logic [3:0] EEPROM_DEV_CODE = 4'b1010;

    typedef struct packed {
        logic        rd;    // 1 = read
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic       rd;
        logic       nack;
        logic [7:0] rdata;  // zero for writes and nacked commands
    } eeprom_rsp_t;

    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_ctrl_wr,
        s_addr,
        s_wdata,
        s_restart,
        s_ctrl_rd,
        s_rdata,
        s_master_nack,
        s_stop
    } seq_state_e;

endpackage

`default_nettype wire

// File: design/eeprom_rsp_out.sv
`default_nettype none
`include "eeprom_params.svh"

module eeprom_rsp_out (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     rsp_push,
    input  wire eeprom_pkg::eeprom_rsp_t rsp_in,
    input  wire                     rsp_credit,
    output logic                    rsp_room,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp
);
    import eeprom_pkg::*;

    localparam int CRED_W = $clog2(`RSP_DEPTH + 1);

    eeprom_rsp_t       head;
    logic              buf_valid;
    logic              pop;
    logic [CRED_W-1:0] credits;  // host slots currently free

    credit_fifo #(
        .T     (eeprom_rsp_t),
        .DEPTH (`RSP_DEPTH)
    ) rsp_buf (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (rsp_push),
        .pop       (pop),
        .din       (rsp_in),
        .dout      (head),
        .not_empty (buf_valid),
        .not_full  (rsp_room)
    );

    assign pop = buf_valid && (credits != '0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            credits   <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= pop;
            case ({rsp_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
            rsp <= head;
    end

    // host never frees more slots than it has
    credit_bound: assert property (@(posedge CLK) disable iff (RESET)
        credits <= CRED_W'(`RSP_DEPTH))
        else $error("response credits above buffer depth");

endmodule

`default_nettype wire

// File: design/i2c_eeprom_master.sv
`default_nettype none
`include "eeprom_params.svh"

module i2c_eeprom_master (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     cmd_ready,
    input  wire eeprom_pkg::eeprom_cmd_t cmd,
    input  wire                     rsp_room,
    input  wire                     scl_in,
    input  wire                     sda_in,
    output logic                    cmd_pop,
    output logic                    rsp_push,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl_oe,
    output logic                    sda_oe
);
    import eeprom_pkg::*;

    localparam int DIV_W = $clog2(`SCL_HALF + 1);
    localparam int MID   = `SCL_HALF / 2;

    seq_state_e       state;
    eeprom_cmd_t      cmd_r;
    logic [DIV_W-1:0] cnt;
    logic             ph;        // 0 = scl low half, 1 = scl high half
    logic             half_end;
    logic             slot_end;
    logic             sample;
    logic             hold;
    logic             late_high;
    logic             sending;
    logic             ack_ok;
    logic [3:0]       bitn;      // 8 = ack slot
    logic [7:0]       sh;        // tx bits out, rx bits in
    logic             nack_r;
    logic             scl_drv;
    logic             sda_drv;

    assign half_end  = (cnt == DIV_W'(`SCL_HALF - 1));
    assign slot_end  = half_end && ph;
    assign sample    = ph && (cnt == DIV_W'(MID));  // middle of scl high
    assign hold      = !ph && (cnt == '0);          // sda moves one cycle after scl falls
    assign late_high = ph && (cnt >= DIV_W'(MID));
    assign sending   = state inside {s_ctrl_wr, s_addr, s_wdata, s_ctrl_rd};
    assign ack_ok    = scl_in && !sda_in;

    assign cmd_pop  = (state == s_idle) && cmd_ready && rsp_room;
    assign rsp_push = (state == s_stop) && slot_end;
    assign rsp      = '{rd: cmd_r.rd,
                        nack: nack_r,
                        rdata: (cmd_r.rd && !nack_r) ? sh : 8'h00};

    always_comb
    begin
        scl_drv = !ph && !(state inside {s_idle, s_start});
        case (state)
            s_start, s_restart:
                sda_drv = hold ? sda_oe : late_high;   // sda falls with scl high
            s_stop:
                sda_drv = hold ? sda_oe : !late_high;  // sda rises with scl high
            s_ctrl_wr, s_addr, s_wdata, s_ctrl_rd:
                sda_drv = hold ? sda_oe : ((bitn != 4'd8) && !sh[7]);
            default:
                sda_drv = 1'b0;  // idle, read bits, master nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end
        else
        begin
            scl_oe <= scl_drv;
            sda_oe <= sda_drv;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET || state == s_idle)
        begin
            cnt <= '0;
            ph  <= 1'b0;
        end
        else if (half_end)
        begin
            cnt <= '0;
            ph  <= !ph;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= s_idle;
            bitn   <= '0;
            nack_r <= 1'b0;
        end
        else if (cmd_pop)
        begin
            cmd_r  <= cmd;
            state  <= s_start;
            bitn   <= '0;
            nack_r <= 1'b0;
        end
        else
        begin
            if (sample && sending && bitn == 4'd8 && !ack_ok)
                nack_r <= 1'b1;
            if (sample && state == s_rdata)
                sh <= {sh[6:0], sda_in};
            if (slot_end)
            begin
                case (state)
                    s_start:
                    begin
                        sh    <= {EEPROM_DEV_CODE, cmd_r.addr[10:8], 1'b0};
                        state <= s_ctrl_wr;
                    end
                    s_ctrl_wr, s_addr, s_wdata, s_ctrl_rd:
                    begin
                        if (bitn != 4'd8)
                        begin
                            sh   <= {sh[6:0], 1'b0};
                            bitn <= bitn + 4'd1;
                        end
                        else if (nack_r)
                        begin
                            bitn  <= '0;
                            state <= s_stop;
                        end
                        else
                        begin
                            bitn <= '0;
                            case (state)
                                s_ctrl_wr:
                                begin
                                    sh    <= cmd_r.addr[7:0];
                                    state <= s_addr;
                                end
                                s_addr:
                                begin
                                    sh    <= cmd_r.wdata;
                                    state <= cmd_r.rd ? s_restart : s_wdata;
                                end
                                s_ctrl_rd:
                                    state <= s_rdata;
                                default:
                                    state <= s_stop;
                            endcase
                        end
                    end
                    s_restart:
                    begin
                        sh    <= {EEPROM_DEV_CODE, cmd_r.addr[10:8], 1'b1};
                        state <= s_ctrl_rd;
                    end
                    s_rdata:
                    begin
                        bitn <= bitn + 4'd1;
                        if (bitn == 4'd7)
                            state <= s_master_nack;
                    end
                    s_master_nack:
                        state <= s_stop;
                    default:
                        state <= s_idle;
                endcase
            end
        end
    end

    // data edges only while scl is held low, start and stop excepted
    sda_edge_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) |-> scl_oe || ($past(state) inside {s_start, s_restart, s_stop}))
        else $error("sda changed with scl high outside start/stop");

    // room is checked once at idle, so the buffer must still have it at the end
    push_has_room: assert property (@(posedge CLK) disable iff (RESET) rsp_push |-> rsp_room)
        else $error("response pushed without room");

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/eeprom_pkg.sv
design/credit_fifo.sv
design/i2c_eeprom_master.sv
design/eeprom_rsp_out.sv
design/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_top -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^Regression passed$" && exit 0 || exit 1

// File: tb/eeprom_model.sv
`default_nettype none

module eeprom_model (
    input  wire  CLK,
    input  wire  scl,
    input  wire  sda,
    input  wire  force_nack,
    output logic sda_oe
);
    timeunit 1ns;
    timeprecision 1ps;
    import eeprom_pkg::*;

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_RX   = 2'd1;
    localparam logic [1:0] M_ACK  = 2'd2;
    localparam logic [1:0] M_TX   = 2'd3;

    logic [7:0]  mem [2048];
    logic [1:0]  mode;
    logic [3:0]  bitcnt;
    logic [7:0]  shreg;
    logic [7:0]  txbyte;
    logic [1:0]  byte_idx;  // 0 control, 1 address, 2 data
    logic [2:0]  hi;
    logic        rd;
    logic [10:0] ptr;
    logic        scl_d;
    logic        sda_d;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3));  // pattern over all address bits
        mode     = M_IDLE;
        bitcnt   = '0;
        byte_idx = '0;
        rd       = 1'b0;
        ptr      = '0;
        hi       = '0;
        shreg    = '0;
        txbyte   = '0;
        scl_d    = 1'b1;
        sda_d    = 1'b1;
        sda_oe   = 1'b0;
    end

    always @(posedge CLK)
    begin
        if (scl && scl_d && sda_d && !sda)
        begin
            mode     = M_RX;  // start or repeated start
            bitcnt   = '0;
            byte_idx = '0;
            sda_oe  <= 1'b0;
        end
        else if (scl && scl_d && !sda_d && sda)
        begin
            mode    = M_IDLE;
            sda_oe <= 1'b0;
        end
        else if (scl && !scl_d && mode == M_RX)
        begin
            shreg  = {shreg[6:0], sda};
            bitcnt = bitcnt + 4'd1;
        end
        else if (!scl && scl_d)
        begin
            case (mode)
                M_RX:
                    if (bitcnt == 4'd8)
                    begin
                        if (byte_idx == 2'd0)
                        begin
                            hi = shreg[3:1];
                            rd = shreg[0];
                        end
                        else if (byte_idx == 2'd1)
                            ptr = {hi, shreg};
                        else if (!force_nack)
                            mem[ptr] = shreg;
                        if (force_nack || (byte_idx == 2'd0 && shreg[7:4] != EEPROM_DEV_CODE))
                            mode = M_IDLE;  // no ack, wait for next start
                        else
                        begin
                            mode    = M_ACK;
                            sda_oe <= 1'b1;
                        end
                    end
                M_ACK:
                    if (rd && byte_idx == 2'd0)
                    begin
                        txbyte  = mem[ptr];
                        sda_oe <= !txbyte[7];
                        bitcnt  = 4'd1;
                        mode    = M_TX;
                    end
                    else
                    begin
                        sda_oe  <= 1'b0;
                        bitcnt   = '0;
                        byte_idx = byte_idx + 2'd1;
                        mode     = M_RX;
                    end
                M_TX:
                    if (bitcnt == 4'd8)
                    begin
                        sda_oe <= 1'b0;  // release for master nack
                        mode    = M_IDLE;
                    end
                    else
                    begin
                        sda_oe <= !txbyte[3'd7 - bitcnt[2:0]];
                        bitcnt  = bitcnt + 4'd1;
                    end
                default: ;
            endcase
        end
        scl_d = scl;
        sda_d = sda;
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`default_nettype none
`include "eeprom_params.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import eeprom_pkg::*;

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    logic        cmd_valid = 1'b0;
    eeprom_cmd_t cmd = '0;
    logic        rsp_credit = 1'b0;
    logic        cmd_credit;
    logic        rsp_valid;
    eeprom_rsp_t rsp;
    logic        scl_oe;
    logic        sda_oe;
    logic        model_sda_oe;
    logic        force_nack = 1'b0;
    wire         scl_line = !scl_oe;
    wire         sda_line = !(sda_oe || model_sda_oe);

    logic [7:0]  ref_mem [2048];
    eeprom_rsp_t exp_q [$];
    eeprom_rsp_t got;
    eeprom_rsp_t want;
    logic        cmp_en = 1'b0;
    logic        orphan = 1'b0;
    logic        reset_chk = 1'b0;
    logic        hold_chk = 1'b0;
    logic        grant_en = 1'b0;
    int          host_credits = `CMD_DEPTH;
    int          given = 0;  // response slots handed to the DUT, not yet returned
    int          errors = 0;
    int          tests = 0;
    int          bad_tests = 0;
    logic [31:0] seed = 32'h4524_b0c6;

    eeprom_ctrl_top dut0 (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd(cmd),
        .rsp_credit(rsp_credit), .scl_in(scl_line), .sda_in(sda_line),
        .cmd_credit(cmd_credit), .rsp_valid(rsp_valid), .rsp(rsp),
        .scl_oe(scl_oe), .sda_oe(sda_oe)
    );

    eeprom_model slave (
        .CLK(CLK), .scl(scl_line), .sda(sda_line),
        .force_nack(force_nack), .sda_oe(model_sda_oe)
    );

    always #20 CLK = !CLK;

    always @(posedge CLK)
    begin
        int next_given;
        next_given = given + int'(rsp_credit) - int'(rsp_valid);
        given <= next_given;
        rsp_credit <= !RESET && grant_en && (next_given < `RSP_DEPTH);
        host_credits <= host_credits + int'(cmd_credit) - int'(cmd_valid);
        cmp_en <= 1'b0;
        orphan <= 1'b0;
        if (rsp_valid)
        begin
            if (exp_q.size() == 0)
                orphan <= 1'b1;
            else
            begin
                want   <= exp_q.pop_front();
                got    <= rsp;
                cmp_en <= 1'b1;
            end
        end
    end

    rsp_match: assert property (@(posedge CLK) cmp_en |-> got == want)
        else
        begin
            errors++;
            $display("ERROR at %0t ns: response %h, expected %h", $time, got, want);
        end
    no_orphan: assert property (@(posedge CLK) !orphan)
        else
        begin
            errors++;
            $display("a response came back with no command outstanding");
        end
    credit_range: assert property (@(posedge CLK) disable iff (RESET)
        host_credits >= 0 && host_credits <= `CMD_DEPTH)
        else
        begin
            errors++;
            $display("ERROR at %0t ns: host credits %0d", $time, host_credits);
        end
    held_back: assert property (@(posedge CLK) hold_chk |-> !rsp_valid)
        else
        begin
            errors++;
            $display("ERROR at %0t ns: rsp_valid without credit", $time);
        end
    idle_after_reset: assert property (@(posedge CLK) reset_chk |->
        !scl_oe && !sda_oe && !rsp_valid && !cmd_credit && scl_line && sda_line)
        else
        begin
            errors++;
            $display("ERROR at %0t ns: outputs not idle after reset", $time);
        end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] next_rand();
        seed = lcg(seed);
        return seed[23:16];
    endfunction

    task automatic send_cmd(input logic rd, input logic [10:0] addr, input logic [7:0] data);
        int n;
        eeprom_rsp_t e;
        n = 0;
        do
        begin
            @(posedge CLK);
            n++;
        end
        while (host_credits == 0 && n < 5000);
        if (n >= 5000)
        begin
            errors++;
            $display("no command credit came back in time");
        end
        cmd_valid <= 1'b1;
        cmd       <= '{rd: rd, addr: addr, wdata: data};
        if (force_nack)
            e = '{rd: rd, nack: 1'b1, rdata: 8'h00};
        else if (rd)
            e = '{rd: 1'b1, nack: 1'b0, rdata: ref_mem[addr]};
        else
        begin
            ref_mem[addr] = data;
            e = '{rd: 1'b0, nack: 1'b0, rdata: 8'h00};
        end
        exp_q.push_back(e);
        @(posedge CLK);
        cmd_valid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        grant_en <= 1'b1;
        while (exp_q.size() != 0 && n < 20000)
        begin
            @(posedge CLK);
            n++;
        end
        if (n >= 20000)
        begin
            errors++;
            $display("responses still missing after the timeout");
        end
        repeat (3) @(posedge CLK);  // let the last compare settle
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
        begin
            bad_tests++;
            $display("%s: FAIL, %0d errors", name, errors - err_before);
        end
    endtask

    initial
    begin
        int e0;
        int n;
        int spare;
        logic [10:0] addrs [8];
        logic [7:0] lo;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'(i ^ (i >> 3));
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        e0 = errors;
        @(posedge CLK);
        reset_chk <= 1'b1;
        repeat (4) @(posedge CLK);
        reset_chk <= 1'b0;
        @(posedge CLK);
        end_test("reset state", e0);

        e0 = errors;
        grant_en <= 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            addrs[i] = 11'({next_rand(), next_rand()});
            send_cmd(1'b0, addrs[i], next_rand());
        end
        for (int i = 0; i < 6; i++)
            send_cmd(1'b1, addrs[i], 8'h00);
        drain();
        end_test("write then read back", e0);

        e0 = errors;
        lo = next_rand();
        for (int i = 0; i < 8; i++)
            send_cmd(1'b0, {3'(i), lo}, 8'(8'h31 * i + 8'h07));
        for (int i = 0; i < 8; i++)
            send_cmd(1'b1, {3'(i), lo}, 8'h00);
        drain();
        end_test("high address bits", e0);

        e0 = errors;
        addrs[0] = 11'({next_rand(), next_rand()});
        force_nack <= 1'b1;
        @(posedge CLK);
        send_cmd(1'b0, addrs[0], ~ref_mem[addrs[0]]);
        send_cmd(1'b1, addrs[0], 8'h00);
        drain();
        force_nack <= 1'b0;
        @(posedge CLK);
        send_cmd(1'b1, addrs[0], 8'h00);
        drain();
        end_test("nack", e0);

        e0 = errors;
        grant_en <= 1'b0;
        repeat (4) @(posedge CLK);
        spare = given;  // credits the DUT still holds from the last drain
        for (int i = 0; i < spare; i++)
            send_cmd(1'b1, 11'({next_rand(), next_rand()}), 8'h00);
        n = 0;
        while (given != 0 && n < 5000)
        begin
            @(posedge CLK);
            n++;
        end
        if (n >= 5000)
        begin
            errors++;
            $display("held response credits were not used up in time");
        end
        hold_chk <= 1'b1;
        for (int i = 0; i < `CMD_DEPTH + `RSP_DEPTH; i++)
            send_cmd(next_rand() > 8'h7f, 11'({next_rand(), next_rand()}), next_rand());
        repeat (400) @(posedge CLK);
        hold_chk <= 1'b0;
        drain();
        end_test("credits and back-pressure", e0);

        $display("%0d tests, %0d with errors, %0d errors in all", tests, bad_tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
